// File: include/keypad_settings.svh
`ifndef KEYPAD_SETTINGS_SVH
`define KEYPAD_SETTINGS_SVH

// Scanner timing
`define KP_SCAN_DWELL        4   // Cycles each column stays driven
`define KP_DEBOUNCE_SCANS    2   // Matching full scans to accept or release

// Word buffer depth in letters
`define KP_WORD_MAX          8

// Key code is {row one-hot, col one-hot}, R0 and C0 in the top bits
`define KP_KEY_SUBMIT_LETTER 8'b0001_1000 // R3 C0, star key
`define KP_KEY_CLEAR         8'b0001_0100 // R3 C1
`define KP_KEY_SUBMIT_WORD   8'b0001_0010 // R3 C2, hash key
`define KP_KEY_GAME_END      8'b0010_0001 // R2 C3

// Four-letter keys
`define KP_KEY_7             8'b0010_1000 // R2 C0, PQRS
`define KP_KEY_9             8'b0010_0010 // R2 C2, WXYZ

// Shown after reset, clear and game end
`define KP_BLANK_CHAR        8'h5F        // Underscore

`endif

// File: rtl/keypad_pkg.sv
`include "keypad_settings.svh"

package keypad_pkg;

  // Position view of a key code
  typedef struct packed {
    logic [3:0] row; // One-hot, R0 in bit 3
    logic [3:0] col; // One-hot, C0 in bit 3
  } key_pos_t;

  // Same byte read whole or by row and column
  typedef union packed {
    logic [7:0] raw; // Compared against the special key codes
    key_pos_t   pos; // Used by the letter lookup
  } key_code_u;

  // Scanner output
  typedef struct packed {
    key_code_u code;  // Level while held, zero when no key
    logic      press; // One cycle at a newly accepted key
  } key_event_t;

  // Multi-tap output
  typedef struct packed {
    logic [7:0] shown;        // Candidate or last character
    logic       letter_valid; // Pulse, letter submitted
    logic       word_submit;  // Level while the word key is held
    logic       game_end;     // Pulse on the game-end press
  } letter_event_t;

  // Collected word
  typedef struct packed {
    logic [`KP_WORD_MAX-1:0][7:0] chars; // Slot 0 is the first letter
    logic [3:0]                   len;
  } word_report_t;

endpackage

// File: rtl/keypad_scanner.sv
`timescale 1ns/1ps
`include "keypad_settings.svh"

module keypad_scanner (
  input  logic                   clk,
  input  logic                   nRst,
  input  logic [3:0]             row_sense,
  output logic [3:0]             col_drive,
  output keypad_pkg::key_event_t key
);
  import keypad_pkg::*;

  localparam int DWELL_W = (`KP_SCAN_DWELL > 1) ? $clog2(`KP_SCAN_DWELL) : 1;
  localparam int MATCH_W = $clog2(`KP_DEBOUNCE_SCANS + 1);
  localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(`KP_SCAN_DWELL - 1);
  localparam logic [MATCH_W-1:0] MATCH_DONE = MATCH_W'(`KP_DEBOUNCE_SCANS);

  logic [1:0]         col_idx;    // Driven column, 0 is C0
  logic [DWELL_W-1:0] dwell_cnt;
  logic               col_last;   // Last cycle on a column, rows sampled here
  logic               scan_end;   // Last cycle of the C3 slot

  key_code_u          col_code;   // Key on the driven column
  logic               col_hit;
  logic               col_multi;  // Two or more rows at once

  key_code_u          acc_code;   // Key collected so far this scan
  logic               acc_multi;
  logic               scan_multi;
  key_code_u          scan_code;  // Result of the whole scan

  key_code_u          cand_code;  // Previous scan result
  logic [MATCH_W-1:0] match_cnt;  // Consecutive scans equal to cand_code
  logic [MATCH_W-1:0] next_match;
  logic               accept;

  assign col_drive = 4'b1000 >> col_idx;
  assign col_last  = (dwell_cnt == DWELL_LAST);
  assign scan_end  = col_last && (col_idx == 2'd3);

  assign col_hit   = |row_sense;
  assign col_multi = |(row_sense & (row_sense - 4'd1)); // Not one-hot

  always_comb begin
    col_code.pos.row = row_sense;
    col_code.pos.col = col_hit ? col_drive : 4'd0;

    // Another key in an earlier column also spoils the scan
    scan_multi = acc_multi | col_multi | (col_hit & (acc_code.raw != 8'd0));

    if (scan_multi)
      scan_code.raw = 8'd0; // Ambiguous, treat as released
    else if (col_hit)
      scan_code = col_code;
    else
      scan_code = acc_code;
  end

  // Saturating run length of identical scans
  assign next_match = (scan_code.raw != cand_code.raw) ? MATCH_W'(1) :
                      (match_cnt == MATCH_DONE)        ? match_cnt :
                                                         match_cnt + 1'b1;
  assign accept     = (next_match == MATCH_DONE);

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      col_idx   <= 2'd0;
      dwell_cnt <= '0;
      acc_code  <= '0;
      acc_multi <= 1'b0;
      cand_code <= '0;
      match_cnt <= '0;
      key       <= '0;
    end else begin
      key.press <= 1'b0; // Strobe lasts one cycle

      if (col_last) begin
        dwell_cnt <= '0;
        col_idx   <= col_idx + 2'd1; // C3 wraps to C0
      end else begin
        dwell_cnt <= dwell_cnt + 1'b1;
      end

      if (scan_end) begin
        acc_code  <= '0;
        acc_multi <= 1'b0;
        cand_code <= scan_code;
        match_cnt <= next_match;
        // Debounced code moves, press only for a real key
        if (accept && (scan_code.raw != key.code.raw)) begin
          key.code  <= scan_code;
          key.press <= |scan_code.raw;
        end
      end else if (col_last) begin
        acc_multi <= scan_multi;
        if (col_hit)
          acc_code <= col_code;
      end
    end
  end

endmodule

// File: rtl/multitap_fsm.sv
`timescale 1ns/1ps
`include "keypad_settings.svh"

module multitap_fsm (
  input  logic                      clk,
  input  logic                      nRst,
  input  keypad_pkg::key_event_t    key,
  output keypad_pkg::letter_event_t letter
);
  import keypad_pkg::*;

  typedef enum logic [2:0] {
    INIT = 3'd0,
    S0   = 3'd1, // First letter of the key
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4, // Only reached on keys 7 and 9
    DONE = 3'd5  // Letter submitted
  } tap_state_t;

  // Keys with no function in this layout
  localparam logic [7:0] KEY_1 = 8'b1000_1000; // R0 C0
  localparam logic [7:0] KEY_A = 8'b1000_0001; // R0 C3
  localparam logic [7:0] KEY_B = 8'b0100_0001; // R1 C3
  localparam logic [7:0] KEY_D = 8'b0001_0001; // R3 C3

  tap_state_t state;
  tap_state_t next_state;
  key_code_u  prev_key;      // Last handled key, for repeat detection
  logic       unlocked;      // Set the cycle after a handled press
  logic [7:0] shown;
  logic [7:0] next_shown;
  logic       ready;         // Letter pulse, one cycle after DONE

  logic       is_invalid;
  logic       is_reset_key;  // Clear or game end
  logic       is_letter_key;
  logic       is_four;       // Key with four letters
  logic       word_submit;
  logic       game_end;

  // Base letter of the key plus the tap offset
  function automatic logic [7:0] tap_char(input key_pos_t pos, input tap_state_t st);
    logic [7:0] base;
    logic [7:0] offset;
    base   = 8'd0;
    offset = 8'd0;

    if (pos.row[3]) begin        // Top row
      if (pos.col[2])
        base = "A";              // Key 2
      else if (pos.col[1])
        base = "D";              // Key 3
    end else if (pos.row[2]) begin
      if (pos.col[3])
        base = "G";
      else if (pos.col[2])
        base = "J";
      else if (pos.col[1])
        base = "M";
    end else if (pos.row[1]) begin
      if (pos.col[3])
        base = "P";              // Key 7
      else if (pos.col[2])
        base = "T";
      else if (pos.col[1])
        base = "W";              // Key 9
    end

    if ((st == S0) || (st == S1) || (st == S2) || (st == S3))
      offset = {5'd0, st} - 8'd1;
    tap_char = base + offset;
  endfunction

  assign is_invalid    = (key.code.raw == KEY_1) || (key.code.raw == KEY_A) ||
                         (key.code.raw == KEY_B) || (key.code.raw == KEY_D);
  assign is_reset_key  = (key.code.raw == `KP_KEY_CLEAR) ||
                         (key.code.raw == `KP_KEY_GAME_END);
  assign is_letter_key = !is_invalid && !is_reset_key &&
                         (key.code.raw != `KP_KEY_SUBMIT_LETTER) &&
                         (key.code.raw != `KP_KEY_SUBMIT_WORD);
  assign is_four       = (key.code.raw == `KP_KEY_7) || (key.code.raw == `KP_KEY_9);

  always_comb begin
    next_state  = state;
    next_shown  = shown;
    word_submit = 1'b0;
    game_end    = 1'b0;

    if (state == DONE)
      next_state = INIT; // DONE lasts one cycle

    // Submit-letter is a level, only acts on a pending letter
    if ((key.code.raw == `KP_KEY_SUBMIT_LETTER) && (state != INIT) && (state != DONE))
      next_state = DONE; // Character stays as shown

    if (key.code.raw == `KP_KEY_SUBMIT_WORD) begin
      next_state  = INIT;
      next_shown  = `KP_BLANK_CHAR;
      word_submit = 1'b1; // Held with the key
    end

    if (key.press) begin
      if (is_reset_key) begin
        next_state = INIT;
        next_shown = `KP_BLANK_CHAR;
        game_end   = (key.code.raw == `KP_KEY_GAME_END);
      end else if (is_letter_key) begin
        if (prev_key.raw == key.code.raw) begin
          case (state)
            INIT:    next_state = S0;
            S0:      next_state = S1;
            S1:      next_state = S2;
            S2:      next_state = is_four ? S3 : S0;
            default: next_state = S0; // S3 wraps, DONE restarts
          endcase
        end else begin
          next_state = S0; // New key starts at its base letter
        end
        next_shown = tap_char(key.code.pos, next_state);
      end
      // Invalid keys leave everything as is
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      state    <= INIT;
      shown    <= `KP_BLANK_CHAR;
      ready    <= 1'b0;
      unlocked <= 1'b0;
      prev_key <= '0;
    end else begin
      state    <= next_state;
      shown    <= next_shown;
      ready    <= (state == DONE);
      unlocked <= key.press && !is_invalid;
      // Remember the key only once its press is handled
      if (unlocked && (key.code.raw != 8'd0))
        prev_key <= key.code;
    end
  end

  assign letter = '{shown:        shown,
                    letter_valid: ready,
                    word_submit:  word_submit,
                    game_end:     game_end};

endmodule

// File: rtl/word_buffer.sv
`timescale 1ns/1ps
`include "keypad_settings.svh"

module word_buffer (
  input  logic                      clk,
  input  logic                      nRst,
  input  keypad_pkg::letter_event_t letter,
  output keypad_pkg::word_report_t  word,
  output logic                      word_valid
);
  import keypad_pkg::*;

  localparam int IDX_W = (`KP_WORD_MAX > 1) ? $clog2(`KP_WORD_MAX) : 1;
  localparam logic [3:0] WORD_MAX = 4'(`KP_WORD_MAX);

  logic [`KP_WORD_MAX-1:0][7:0] chars; // Letters in arrival order
  logic [3:0]                   count; // Letters held
  logic                         submit_q;
  logic                         submit_rise;
  logic                         flush;    // Empty the buffer this cycle
  logic                         append;

  assign submit_rise = letter.word_submit && !submit_q; // Report once per hold
  assign flush       = submit_rise || letter.game_end;
  assign append      = letter.letter_valid && (count != WORD_MAX) && !flush; // Drop when full

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      count      <= 4'd0;
      submit_q   <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      submit_q   <= letter.word_submit;
      word_valid <= submit_rise;
      if (flush)
        count <= 4'd0;
      else if (append)
        count <= count + 4'd1;
    end
  end

  // Letter storage
  always_ff @(posedge clk) begin
    if (append)
      chars[count[IDX_W-1:0]] <= letter.shown;
  end

  // Report snapshot, unused slots zeroed
  always_ff @(posedge clk) begin
    if (submit_rise) begin
      word.len <= count;
      for (int i = 0; i < `KP_WORD_MAX; i++) begin
        word.chars[i] <= (i < int'(count)) ? chars[i] : 8'd0;
      end
    end
  end

endmodule

// File: rtl/keypad_word_entry.sv
`timescale 1ns/1ps

module keypad_word_entry (
  input  logic                     clk,
  input  logic                     nRst,
  input  logic [3:0]               row_sense,
  output logic [3:0]               col_drive,
  output logic [7:0]               shown_char,
  output logic                     letter_valid,
  output logic                     game_end,
  output keypad_pkg::word_report_t word,
  output logic                     word_valid
);
  import keypad_pkg::*;

  key_event_t    key;    // Scanner to FSM
  letter_event_t letter; // FSM to buffer and outputs

  keypad_scanner i_keypad_scanner (
    .clk       (clk),
    .nRst      (nRst),
    .row_sense (row_sense),
    .col_drive (col_drive),
    .key       (key)
  );

  multitap_fsm i_multitap_fsm (
    .clk    (clk),
    .nRst   (nRst),
    .key    (key),
    .letter (letter)
  );

  word_buffer i_word_buffer (
    .clk        (clk),
    .nRst       (nRst),
    .letter     (letter),
    .word       (word),
    .word_valid (word_valid)
  );

  assign shown_char   = letter.shown;
  assign letter_valid = letter.letter_valid;
  assign game_end     = letter.game_end;

endmodule

// File: bench/keypad_clock_gen.sv
`timescale 1ns/1ps

module keypad_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic nRst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk; // Free running
  end

  // Reset low from time zero, released on a rising edge
  initial begin
    nRst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    nRst <= 1'b1;
  end

endmodule

// File: bench/keypad_matrix_model.sv
`timescale 1ns/1ps

// One pressed key shorts its row to its column
module keypad_matrix_model (
  input  logic [3:0]            col_drive, // One-hot, C0 in bit 3
  input  keypad_pkg::key_code_u pressed,   // Zero when no key is down
  output logic [3:0]            row_sense  // Active high, R0 in bit 3
);
  import keypad_pkg::*;

  logic col_match;

  assign col_match = |(col_drive & pressed.pos.col); // Driven column holds the key
  assign row_sense = col_match ? pressed.pos.row : 4'd0;

endmodule

// File: bench/tb_keypad_word_entry.sv
`timescale 1ns/1ps
`include "keypad_settings.svh"

module tb_keypad_word_entry;
  import keypad_pkg::*;

  localparam int HOLD       = 2 * (`KP_DEBOUNCE_SCANS + 1) * 4 * `KP_SCAN_DWELL; // Cycles
  localparam int NUM_STIM   = 53;
  localparam int MAX_REPEAT = 3; // Most applications of one entry in the random pass
  localparam longint WATCH_NS = longint'(NUM_STIM * (1 + MAX_REPEAT) + 2) * 2 * HOLD * 100;

  // Key codes as {row, col}, one-hot, R0 and C0 in the top bits
  localparam logic [7:0] K1 = 8'b1000_1000;
  localparam logic [7:0] K2 = 8'b1000_0100;
  localparam logic [7:0] K3 = 8'b1000_0010;
  localparam logic [7:0] KA = 8'b1000_0001;
  localparam logic [7:0] K4 = 8'b0100_1000;
  localparam logic [7:0] K5 = 8'b0100_0100;
  localparam logic [7:0] K6 = 8'b0100_0010;
  localparam logic [7:0] KB = 8'b0100_0001;
  localparam logic [7:0] K7 = `KP_KEY_7;
  localparam logic [7:0] K8 = 8'b0010_0100;
  localparam logic [7:0] K9 = `KP_KEY_9;
  localparam logic [7:0] KD = 8'b0001_0001;
  localparam logic [7:0] SL = `KP_KEY_SUBMIT_LETTER;
  localparam logic [7:0] CL = `KP_KEY_CLEAR;
  localparam logic [7:0] SW = `KP_KEY_SUBMIT_WORD;
  localparam logic [7:0] GE = `KP_KEY_GAME_END;
  localparam logic       TAP  = 1'b1; // May get extra taps in the random pass
  localparam logic       ONCE = 1'b0;

  // {key, tap flag}
  localparam logic [8:0] STIM [NUM_STIM] = '{
    {K2, TAP}, {K2, TAP}, {K2, TAP}, {K2, TAP}, {K3, TAP}, {SL, ONCE},
    {K3, TAP}, {K3, TAP}, {K1, ONCE}, {K3, TAP}, {SL, ONCE}, {SL, ONCE},
    {K9, TAP}, {K9, TAP}, {K9, TAP}, {K9, TAP}, {K9, TAP}, {KA, ONCE},
    {SL, ONCE}, {SW, ONCE}, {K7, TAP}, {K7, TAP}, {K7, TAP}, {K7, TAP},
    {SL, ONCE}, {CL, ONCE}, {K8, TAP}, {CL, ONCE}, {K8, TAP}, {SL, ONCE},
    {KB, ONCE}, {KD, ONCE}, {GE, ONCE}, {SW, ONCE}, {K4, TAP}, {SL, ONCE},
    {K5, TAP}, {SL, ONCE}, {K6, TAP}, {SL, ONCE}, {K2, TAP}, {SL, ONCE},
    {K3, TAP}, {SL, ONCE}, {K4, TAP}, {SL, ONCE}, {K5, TAP}, {SL, ONCE},
    {K6, TAP}, {SL, ONCE}, {K8, TAP}, {SL, ONCE}, {SW, ONCE}
  };

  logic         clk;
  logic         nRst;
  logic [7:0]   pressed;    // Key held in the matrix model
  logic [3:0]   row_sense;
  logic [3:0]   col_drive;
  logic [7:0]   shown_char;
  logic         letter_valid;
  logic         game_end;
  word_report_t word;
  logic         word_valid;

  // Reference model state
  logic [7:0]   prev_key;   // Last letter key
  int           tap_idx;
  bit           pending;    // Candidate letter on show
  logic [7:0]   exp_shown;
  logic [7:0]   exp_chars [`KP_WORD_MAX];
  int           exp_len;
  int           col_cycles; // Clock cycles since reset release

  keypad_clock_gen i_keypad_clock_gen (.clk(clk), .nRst(nRst));

  keypad_matrix_model i_keypad_matrix_model (
    .col_drive (col_drive),
    .pressed   (pressed),
    .row_sense (row_sense)
  );

  keypad_word_entry i_keypad_word_entry (
    .clk          (clk),
    .nRst         (nRst),
    .row_sense    (row_sense),
    .col_drive    (col_drive),
    .shown_char   (shown_char),
    .letter_valid (letter_valid),
    .game_end     (game_end),
    .word         (word),
    .word_valid   (word_valid)
  );

  // Letters on a key, zero for keys without letters
  function automatic int letter_count(input logic [7:0] code);
    case (code)
      K7, K9:                 letter_count = 4;
      K2, K3, K4, K5, K6, K8: letter_count = 3;
      default:                letter_count = 0;
    endcase
  endfunction

  function automatic logic [7:0] base_letter(input logic [7:0] code);
    case (code)
      K2:      base_letter = "A";
      K3:      base_letter = "D";
      K4:      base_letter = "G";
      K5:      base_letter = "J";
      K6:      base_letter = "M";
      K7:      base_letter = "P";
      K8:      base_letter = "T";
      K9:      base_letter = "W";
      default: base_letter = 8'd0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Press, hold and release one key, then compare with the model
  task automatic apply_key(input logic [7:0] code);
    int           cyc;
    int           i;
    int           nl;
    int           n_letter;
    int           n_game;
    int           n_word;
    logic [7:0]   seen_char;
    word_report_t seen_word;
    bit           want_letter;
    bit           want_game;
    bit           want_word;
    logic [7:0]   want_char;
    logic [63:0]  want_chars;
    int           want_len;
    n_letter    = 0;
    n_game      = 0;
    n_word      = 0;
    seen_char   = 8'd0;
    seen_word   = '0;
    want_letter = 1'b0;
    want_game   = 1'b0;
    want_word   = 1'b0;
    want_char   = 8'd0;
    want_chars  = '0;
    want_len    = 0;
    nl          = letter_count(code);

    if (nl != 0) begin
      tap_idx   = (pending && (prev_key == code)) ? (tap_idx + 1) % nl : 0; // Same key cycles
      pending   = 1'b1;
      prev_key  = code;
      exp_shown = base_letter(code) + 8'(tap_idx);
    end else if (code == SL) begin
      if (pending) begin
        want_letter = 1'b1;
        want_char   = exp_shown;
        if (exp_len < `KP_WORD_MAX) begin // Extra letters dropped
          exp_chars[exp_len] = exp_shown;
          exp_len++;
        end
      end
      pending = 1'b0;
    end else if (code == SW) begin
      want_word = 1'b1;
      want_len  = exp_len;
      for (i = 0; i < exp_len; i++)
        want_chars[i*8 +: 8] = exp_chars[i];
      exp_len   = 0;
      exp_shown = `KP_BLANK_CHAR;
      pending   = 1'b0;
    end else if ((code == CL) || (code == GE)) begin
      want_game = (code == GE);
      if (code == GE)
        exp_len = 0; // Word thrown away
      exp_shown = `KP_BLANK_CHAR;
      pending   = 1'b0;
    end
    // Invalid keys and no key leave the model alone

    for (cyc = 0; cyc < 2 * HOLD; cyc++) begin
      @(posedge clk);
      if (cyc == 0)
        pressed <= code;
      else if (cyc == HOLD)
        pressed <= 8'd0; // Release for the second half
      @(negedge clk);
      if (letter_valid) begin
        n_letter++;
        seen_char = shown_char;
      end
      if (game_end)
        n_game++;
      if (word_valid) begin
        n_word++;
        seen_word = word;
      end
    end

    check_value("letter_valid pulses", n_letter, want_letter);
    if (want_letter)
      check_value("shown_char at letter_valid", seen_char, want_char);
    check_value("game_end pulses", n_game, want_game);
    if (!want_word && (n_word != 0)) begin
      $display("Unexpected word_valid pulse after key %h, at %0t ns", code, $time);
      $display("Errors found");
      $fatal(1);
    end else if (want_word) begin
      check_value("word_valid pulses", n_word, 1);
      check_value("word.len", seen_word.len, want_len);
      check_value("word.chars", seen_word.chars, want_chars);
    end
    check_value("shown_char", shown_char, exp_shown);
  endtask

  // Columns rotate from C0, one per dwell period
  always @(negedge clk) begin
    logic [3:0] exp_col;
    if (nRst === 1'b1) begin
      exp_col = 4'd0;
      exp_col[3 - (col_cycles / `KP_SCAN_DWELL) % 4] = 1'b1; // Bit 3 is C0
      check_value("col_drive", col_drive, exp_col);
      col_cycles++;
    end
  end

  initial begin
    #(WATCH_NS);
    $display("Timeout after %0d ns, stimulus did not complete", WATCH_NS);
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    int idx;
    int reps;
    int r;
    void'($urandom(32'h9d26857d));
    pressed    = 8'd0;
    prev_key   = 8'd0;
    tap_idx    = 0;
    pending    = 1'b0;
    exp_shown  = `KP_BLANK_CHAR;
    exp_len    = 0;
    col_cycles = 0;

    wait (nRst === 1'b1);
    apply_key(8'd0); // Idle after reset, nothing may pulse

    for (idx = 0; idx < NUM_STIM; idx++)
      apply_key(STIM[idx][8:1]);

    // Random pass, letter keys tapped one to three times
    for (idx = 0; idx < NUM_STIM; idx++) begin
      reps = STIM[idx][0] ? 1 + int'($urandom % MAX_REPEAT) : 1;
      for (r = 0; r < reps; r++)
        apply_key(STIM[idx][8:1]);
    end

    $display("No errors");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
rtl/keypad_pkg.sv
rtl/keypad_scanner.sv
rtl/multitap_fsm.sv
rtl/word_buffer.sv
rtl/keypad_word_entry.sv
bench/keypad_clock_gen.sv
bench/keypad_matrix_model.sv
bench/tb_keypad_word_entry.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the keypad word entry testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 \
  --top-module tb_keypad_word_entry \
  --Mdir "$OBJ" \
  -f tb.f

# The log decides the result
"./$OBJ/Vtb_keypad_word_entry" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
